/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= riscv_core.f
TOP       ?= tb_riscv_core
RTL_TOP   ?= riscv_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RTL_SRCS  ?= common/rv_pkg.sv core/fetch_unit.sv core/decoder.sv core/reg_file.sv \
             core/alu.sv core/lsu.sv core/riscv_core.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -Wno-fatal $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      strobe_t;  // One enable per byte lane
  typedef logic [3:0]      alu_op_t;

  localparam word_t RESET_PC = 32'h0000_0000;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;  // LUI

  // Major opcodes
  localparam logic [6:0] OP_LOAD     = 7'b000_0011;
  localparam logic [6:0] OP_STORE    = 7'b010_0011;
  localparam logic [6:0] OP_BRANCH   = 7'b110_0011;
  localparam logic [6:0] OP_JALR     = 7'b110_0111;
  localparam logic [6:0] OP_JAL      = 7'b110_1111;
  localparam logic [6:0] OP_MISC_MEM = 7'b000_1111;
  localparam logic [6:0] OP_IMM      = 7'b001_0011;
  localparam logic [6:0] OP_REG      = 7'b011_0011;
  localparam logic [6:0] OP_SYSTEM   = 7'b111_0011;
  localparam logic [6:0] OP_AUIPC    = 7'b001_0111;
  localparam logic [6:0] OP_LUI      = 7'b011_0111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Memory access size and sign
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       reg_we;
    alu_op_t    alu_op;
    logic       b_is_imm;
    logic       a_is_pc;
    word_t      imm;
    logic       is_load;
    logic       is_store;
    logic [2:0] mem_funct3;  // Size and unsigned flag
    logic       is_branch;
    logic [2:0] br_funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_ecall;
  } ctrl_t;

endpackage

`default_nettype wire

/* core/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
  input  wire ctrl_t ctrl,
  input  wire word_t pc,
  input  wire word_t rs1_data,
  input  wire word_t rs2_data,
  output word_t      result,
  output logic       branch_taken
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       cond;

  assign op_a  = ctrl.a_is_pc ? pc : rs1_data;
  assign op_b  = ctrl.b_is_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {31'd0, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // Compare always on the register values, never on the immediate
  always_comb begin
    case (ctrl.br_funct3)
      F3_BEQ:  cond = (rs1_data == rs2_data);
      F3_BNE:  cond = (rs1_data != rs2_data);
      F3_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: cond = (rs1_data < rs2_data);
      F3_BGEU: cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = ctrl.is_branch && cond;

endmodule

`default_nettype wire

/* core/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder import rv_pkg::*; (
  input  wire word_t insn,
  output ctrl_t      ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic       is_reg;
  logic       f7_zero;
  logic       f7_alt;
  alu_op_t    alu_sel;
  logic       alu_legal;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign is_reg  = (opcode == OP_REG);
  assign f7_zero = (funct7 == 7'b000_0000);
  assign f7_alt  = (funct7 == 7'b010_0000);  // SUB and SRA

  // ALU mapping shared by register-immediate and register-register forms
  always_comb begin
    alu_legal = !is_reg || f7_zero;
    case (funct3)
      3'b000: begin
        alu_sel   = (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
        alu_legal = !is_reg || f7_zero || f7_alt;
      end
      3'b001: begin
        alu_sel   = ALU_SLL;
        alu_legal = f7_zero;
      end
      3'b010: alu_sel = ALU_SLT;
      3'b011: alu_sel = ALU_SLTU;
      3'b100: alu_sel = ALU_XOR;
      3'b101: begin
        alu_sel   = f7_alt ? ALU_SRA : ALU_SRL;
        alu_legal = f7_zero || f7_alt;
      end
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl        = '0;  // Anything unmatched stays a no-op
    ctrl.rs1    = insn[19:15];
    ctrl.rs2    = insn[24:20];
    ctrl.rd     = insn[11:7];
    ctrl.alu_op = ALU_ADD;
    case (opcode)
      OP_LUI: begin
        ctrl.reg_we   = 1'b1;
        ctrl.alu_op   = ALU_PASS_B;
        ctrl.b_is_imm = 1'b1;
        ctrl.imm      = imm_u;
      end
      OP_AUIPC: begin
        ctrl.reg_we   = 1'b1;
        ctrl.a_is_pc  = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.imm      = imm_u;
      end
      OP_JAL: begin
        ctrl.reg_we = 1'b1;
        ctrl.is_jal = 1'b1;
        ctrl.imm    = imm_j;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          ctrl.reg_we   = 1'b1;
          ctrl.is_jalr  = 1'b1;
          ctrl.b_is_imm = 1'b1;
          ctrl.imm      = imm_i;
        end
      end
      OP_BRANCH: begin
        if (funct3[2:1] != 2'b01) begin  // 010 and 011 are reserved
          ctrl.is_branch = 1'b1;
          ctrl.br_funct3 = funct3;
          ctrl.imm       = imm_b;
        end
      end
      OP_LOAD: begin
        if (funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) begin
          ctrl.reg_we     = 1'b1;
          ctrl.is_load    = 1'b1;
          ctrl.b_is_imm   = 1'b1;
          ctrl.imm        = imm_i;
          ctrl.mem_funct3 = funct3;
        end
      end
      OP_STORE: begin
        if (funct3 inside {F3_B, F3_H, F3_W}) begin
          ctrl.is_store   = 1'b1;
          ctrl.b_is_imm   = 1'b1;
          ctrl.imm        = imm_s;
          ctrl.mem_funct3 = funct3;
        end
      end
      OP_IMM: begin
        if (alu_legal) begin
          ctrl.reg_we   = 1'b1;
          ctrl.alu_op   = alu_sel;
          ctrl.b_is_imm = 1'b1;
          ctrl.imm      = imm_i;
        end
      end
      OP_REG: begin
        if (alu_legal) begin
          ctrl.reg_we = 1'b1;
          ctrl.alu_op = alu_sel;
        end
      end
      OP_MISC_MEM: ;  // FENCE, nothing to order here
      OP_SYSTEM: begin
        ctrl.is_ecall = (insn[31:7] == 25'd0);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* core/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire ctrl_t ctrl,
  input  wire logic  branch_taken,
  input  wire word_t alu_result,
  output word_t      pc,
  output logic       halt,
  output logic       active
);

  logic  halted;
  word_t next_pc;

  // Instruction at pc may change state only out of reset and before ECALL
  assign active = !rst && !halted;
  assign halt   = halted;

  always_comb begin
    next_pc = pc + 32'd4;
    if (ctrl.is_jalr) begin
      next_pc = {alu_result[XLEN-1:1], 1'b0};  // Target bit zero dropped
    end else if (branch_taken || ctrl.is_jal) begin
      next_pc = pc + ctrl.imm;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else if (active) begin
      if (ctrl.is_ecall) begin
        halted <= 1'b1;  // pc stays on the ECALL
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

/* core/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu import rv_pkg::*; (
  input  wire ctrl_t ctrl,
  input  wire logic  active,
  input  wire word_t addr,
  input  wire word_t rs2_data,
  input  wire word_t dmem_rdata,
  output word_t      dmem_addr,
  output word_t      dmem_wdata,
  output strobe_t    dmem_strobe,
  output word_t      load_data,
  output logic       load_ok
);

  logic [1:0] offset;
  logic       misaligned;
  strobe_t    lane_mask;
  word_t      lane;

  assign offset    = addr[1:0];
  assign dmem_addr = {addr[XLEN-1:2], 2'b00};

  always_comb begin
    case (ctrl.mem_funct3)
      F3_H, F3_HU: misaligned = offset[0];
      F3_W:        misaligned = (offset != 2'b00);
      default:     misaligned = 1'b0;  // Bytes always fit
    endcase
  end

  // Store value copied into every lane, strobe picks the real one
  always_comb begin
    case (ctrl.mem_funct3)
      F3_B: begin
        dmem_wdata = {4{rs2_data[7:0]}};
        lane_mask  = strobe_t'(4'b0001 << offset);
      end
      F3_H: begin
        dmem_wdata = {2{rs2_data[15:0]}};
        lane_mask  = strobe_t'(4'b0011 << offset);
      end
      default: begin
        dmem_wdata = rs2_data;
        lane_mask  = 4'b1111;
      end
    endcase
  end

  assign dmem_strobe = (ctrl.is_store && active && !misaligned) ? lane_mask : '0;

  assign lane = dmem_rdata >> {offset, 3'b000};  // Addressed byte down to bit 0

  always_comb begin
    case (ctrl.mem_funct3)
      F3_B:    load_data = {{24{lane[7]}}, lane[7:0]};
      F3_BU:   load_data = {24'd0, lane[7:0]};
      F3_H:    load_data = {{16{lane[15]}}, lane[15:0]};
      F3_HU:   load_data = {16'd0, lane[15:0]};
      default: load_data = dmem_rdata;
    endcase
  end

  assign load_ok = !misaligned;

endmodule

`default_nettype wire

/* core/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire reg_idx_t rs1,
  input  wire reg_idx_t rs2,
  input  wire reg_idx_t rd,
  input  wire logic     we,
  input  wire word_t    wdata,
  output word_t         rs1_data,
  output word_t         rs2_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 never written
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* core/riscv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_core import rv_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  output word_t      pc,
  input  wire word_t insn,
  output word_t      dmem_addr,
  output word_t      dmem_wdata,
  output strobe_t    dmem_strobe,
  input  wire word_t dmem_rdata,
  output logic       halt
);

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic  branch_taken;
  logic  active;
  word_t load_data;
  logic  load_ok;
  logic  rf_we;
  word_t rf_wdata;

  fetch_unit u_fetch (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .alu_result   (alu_result),
    .pc           (pc),
    .halt         (halt),
    .active       (active)
  );

  decoder u_decoder (
    .insn (insn),
    .ctrl (ctrl)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .we       (rf_we),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .ctrl         (ctrl),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  lsu u_lsu (
    .ctrl        (ctrl),
    .active      (active),
    .addr        (alu_result),  // rs1 plus offset
    .rs2_data    (rs2_data),
    .dmem_rdata  (dmem_rdata),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_strobe (dmem_strobe),
    .load_data   (load_data),
    .load_ok     (load_ok)
  );

  // Write-back source
  always_comb begin
    if (ctrl.is_load) begin
      rf_wdata = load_data;
    end else if (ctrl.is_jal || ctrl.is_jalr) begin
      rf_wdata = pc + 32'd4;  // Link address
    end else begin
      rf_wdata = alu_result;
    end
  end

  assign rf_we = ctrl.reg_we && active && (!ctrl.is_load || load_ok);

endmodule

`default_nettype wire

/* dv/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model import rv_pkg::*; (
  input  wire logic    clk,
  input  wire word_t   imem_addr,
  output word_t        imem_rdata,
  input  wire word_t   dmem_addr,
  input  wire word_t   dmem_wdata,
  input  wire strobe_t dmem_strobe,
  output word_t        dmem_rdata
);

  localparam int DEPTH = 256;  // 1 KiB of words

  word_t mem [DEPTH];

  // Untouched words get noise so a missing lane write is visible
  task automatic fill_random();
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] <= $urandom();
    end
  endtask

  task automatic load_word(input int idx, input word_t value);
    mem[idx] <= value;
  endtask

  assign imem_rdata = mem[imem_addr[9:2]];
  assign dmem_rdata = mem[dmem_addr[9:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_strobe[b]) begin
        mem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* dv/riscv_core_trace.hex */
// Word 0 program length, then program words, then store event count
// Events: address, lane-masked data, strobe, behavior number; last word halt address
00000028
10000513 // 00 addi x10,x0,256
FFB00093 // 04 addi x1,x0,-5
00409113 // 08 slli x2,x1,4
40215193 // 0C srai x3,x2,2
40118233 // 10 sub  x4,x3,x1
0000A2B3 // 14 slt  x5,x1,x0
12345337 // 18 lui  x6,0x12345
00001397 // 1C auipc x7,1
00434433 // 20 xor  x8,x6,x4
00352023 // 24 sw x3,0(x10)
00452223 // 28 sw x4,4(x10)
00552423 // 2C sw x5,8(x10)
00852623 // 30 sw x8,12(x10)
00752823 // 34 sw x7,16(x10)
00150AA3 // 38 sb x1,21(x10)
00451B23 // 3C sh x4,22(x10)
01550583 // 40 lb  x11,21(x10)
01554603 // 44 lbu x12,21(x10)
01651683 // 48 lh  x13,22(x10)
01655703 // 4C lhu x14,22(x10)
00B52C23 // 50 sw x11,24(x10)
00C52E23 // 54 sw x12,28(x10)
02D52023 // 58 sw x13,32(x10)
02E52223 // 5C sw x14,36(x10)
00028463 // 60 beq x5,x0,+8 not taken
02552423 // 64 sw x5,40(x10)
0000C463 // 68 blt x1,x0,+8 taken
02152623 // 6C sw x1,44(x10) skipped
008007EF // 70 jal x15,+8
02152823 // 74 sw x1,48(x10) skipped
00C78867 // 78 jalr x16,12(x15)
02152A23 // 7C sw x1,52(x10) skipped
02F52C23 // 80 sw x15,56(x10)
03052E23 // 84 sw x16,60(x10)
00252283 // 88 lw x5,2(x10) misaligned
001510A3 // 8C sh x1,1(x10) misaligned
0FF0000F // 90 fence
04552023 // 94 sw x5,64(x10)
00000073 // 98 ecall
04152223 // 9C sw x1,68(x10) never runs
0000000F
00000100 FFFFFFEC 0000000F 00000002
00000104 FFFFFFF1 0000000F 00000002
00000108 00000001 0000000F 00000002
0000010C EDCBAFF1 0000000F 00000002
00000110 0000101C 0000000F 00000002
00000114 0000FB00 00000002 00000003
00000114 FFF10000 0000000C 00000003
00000118 FFFFFFFB 0000000F 00000003
0000011C 000000FB 0000000F 00000003
00000120 FFFFFFF1 0000000F 00000003
00000124 0000FFF1 0000000F 00000003
00000128 00000001 0000000F 00000004
00000138 00000074 0000000F 00000004
0000013C 0000007C 0000000F 00000004
00000140 00000001 0000000F 00000005
00000098

/* dv/tb_riscv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core import rv_pkg::*; ();

  localparam int TRACE_DEPTH = 256;
  localparam int RESET_CYCLES = 8;

  logic    clk;
  logic    rst;
  word_t   pc;
  word_t   insn;
  word_t   dmem_addr;
  word_t   dmem_wdata;
  strobe_t dmem_strobe;
  word_t   dmem_rdata;
  logic    halt;

  word_t trace [TRACE_DEPTH];
  int    test_errs [1:6];
  int    prog_len;
  int    n_events;
  int    ev_base;
  int    ev_idx;
  word_t halt_addr;

  riscv_core uut (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .insn        (insn),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_strobe (dmem_strobe),
    .dmem_rdata  (dmem_rdata),
    .halt        (halt)
  );

  mem_model u_mem (
    .clk         (clk),
    .imem_addr   (pc),
    .imem_rdata  (insn),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_strobe (dmem_strobe),
    .dmem_rdata  (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic word_t lane_mask(input strobe_t strb);
    word_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  task automatic compare_word(input int tag, input string name, input word_t expected,
                              input word_t actual);
    if (expected !== actual) begin
      $display("Fail %0t %s expected %h got %h", $time, name, expected, actual);
      test_errs[tag]++;
    end
  endtask

  // Next expected event; fourth column names the behavior it belongs to
  task automatic check_store();
    int    base;
    int    tag;
    word_t masked;
    if (ev_idx >= n_events) begin
      $display("Error at %0t: store to %h after all expected stores were seen",
               $time, dmem_addr);
      test_errs[6]++;
    end else begin
      base   = ev_base + 4 * ev_idx;
      tag    = int'(trace[base + 3]);
      masked = dmem_wdata & lane_mask(dmem_strobe);
      compare_word(tag, "dmem_addr", trace[base], dmem_addr);
      compare_word(tag, "dmem_wdata", trace[base + 1], masked);
      compare_word(tag, "dmem_strobe", trace[base + 2], word_t'(dmem_strobe));
      ev_idx++;
    end
  endtask

  initial begin
    int    cycles;
    int    limit;
    int    failed;
    int    total;
    logic  timed_out;
    logic  running;
    string names [1:6];
    names[1] = "reset state";
    names[2] = "integer ops, LUI, AUIPC";
    names[3] = "byte and halfword access";
    names[4] = "branches and jumps";
    names[5] = "misaligned access";
    names[6] = "ECALL halt";
    rst       = 1'b1;
    timed_out = 1'b0;
    running   = 1'b1;
    cycles    = 0;
    ev_idx    = 0;
    for (int t = 1; t <= 6; t++) begin
      test_errs[t] = 0;
    end
    void'($urandom(32'hb01480ec));
    $readmemh("dv/riscv_core_trace.hex", trace);
    prog_len  = int'(trace[0]);
    n_events  = int'(trace[prog_len + 1]);
    ev_base   = prog_len + 2;
    halt_addr = trace[ev_base + 4 * n_events];
    limit     = prog_len * 4 + RESET_CYCLES + 20;
    u_mem.fill_random();
    for (int i = 0; i < prog_len; i++) begin
      u_mem.load_word(i, trace[i + 1]);
    end

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      compare_word(1, "pc", RESET_PC, pc);
      compare_word(1, "halt", 32'd0, word_t'(halt));
      compare_word(1, "dmem_strobe", 32'd0, word_t'(dmem_strobe));
    end
    @(posedge clk);
    #1 rst = 1'b0;

    while (running) begin
      @(negedge clk);
      cycles++;
      if (cycles == 1) begin
        compare_word(1, "pc", RESET_PC, pc);  // First cycle out of reset
        compare_word(1, "halt", 32'd0, word_t'(halt));
        compare_word(1, "dmem_strobe", 32'd0, word_t'(dmem_strobe));
      end
      if (halt) begin
        running = 1'b0;
      end else if (cycles > limit) begin
        $display("Timeout at %0t: halt never rose within %0d cycles", $time, limit);
        test_errs[6]++;
        timed_out = 1'b1;
        running   = 1'b0;
      end else if (dmem_strobe != '0) begin
        check_store();
      end
    end

    if (!timed_out) begin
      repeat (4) begin
        compare_word(6, "halt", 32'd1, word_t'(halt));
        compare_word(6, "pc", halt_addr, pc);
        compare_word(6, "dmem_strobe", 32'd0, word_t'(dmem_strobe));
        @(negedge clk);
      end
      if (ev_idx != n_events) begin
        $display("Error: saw %0d of %0d expected store events", ev_idx, n_events);
        test_errs[6]++;
      end
    end

    failed = 0;
    total  = 0;
    for (int t = 1; t <= 6; t++) begin
      $display("Test %0d %s: %s (%0d errors)", t, names[t],
               (test_errs[t] == 0) ? "passed" : "failed", test_errs[t]);
      failed += (test_errs[t] != 0);
      total  += test_errs[t];
    end
    $display("Tests: %0d passed, %0d failed, %0d errors", 6 - failed, failed, total);
    if (total == 0 && !timed_out) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* riscv_core.f */
common/rv_pkg.sv
core/fetch_unit.sv
core/decoder.sv
core/reg_file.sv
core/alu.sv
core/lsu.sv
core/riscv_core.sv
dv/mem_model.sv
dv/tb_riscv_core.sv
